/* Bender.yml */
package:
  name: icache_2way

sources:
  - target: rtl
    files:
      - logic/icache_pkg.sv
      - logic/dp_ram.sv
      - logic/icache_way.sv
      - logic/icache_fill.sv
      - logic/icache_2way.sv
  - target: test
    files:
      - tb/mem_model.sv
      - tb/icache_tb.sv

/* files.f */
logic/icache_pkg.sv
logic/dp_ram.sv
logic/icache_way.sv
logic/icache_fill.sv
logic/icache_2way.sv
tb/mem_model.sv
tb/icache_tb.sv

/* logic/dp_ram.sv */
/*
 * Dual-port RAM, one registered read port and one write port,
 * with a type parameter for the stored payload
 */
`timescale 1ns/1ps
`default_nettype none

module dp_ram #(
  parameter int DEPTH = 256,
  parameter type payload_t = logic
) (
  input  wire logic                     clk,
  input  wire logic [$clog2(DEPTH)-1:0] rd_addr,
  output payload_t                      rd_data,
  input  wire logic                     wr_en,
  input  wire logic [$clog2(DEPTH)-1:0] wr_addr,
  input  wire payload_t                 wr_data
);

  payload_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // A read on the writing edge returns the new payload
  always_ff @(posedge clk) begin
    if (wr_en && wr_addr == rd_addr) begin
      rd_data <= wr_data;
    end else begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

/* logic/icache_2way.sv */
/*
 * Two-way set-associative instruction cache with LRU replacement,
 * critical word first fill and a bypass path when disabled
 */
`timescale 1ns/1ps
`default_nettype none

module icache_2way (
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire logic                   enabled,
  input  wire icache_pkg::fetch_req_t cpu_req,
  output icache_pkg::word_t           c_data,
  output logic                        c_ack,
  output icache_pkg::fetch_req_t      mem_req,
  input  wire icache_pkg::word_t      m_data,
  input  wire logic                   m_ack
);

  import icache_pkg::*;

  logic               lookup_valid;
  addr_t              lookup_addr;
  addr_t              mem_addr;
  logic               mem_access;
  logic               filling;
  logic [INDEX_W-1:0] fill_set;
  logic [LINE_WORDS-1:0] filled_mask;
  logic               victim_way;
  logic               tag_wr0;
  logic               tag_wr1;
  tag_entry_t         tag_wr_data;
  logic               data_wr0;
  logic               data_wr1;
  logic               lru_wr;
  logic               init_busy;
  logic               tag_hit0;
  logic               tag_hit1;
  word_t              data0;
  word_t              data1;
  logic               in_window;
  logic               hit0;
  logic               hit1;
  logic               c_hit;
  logic               lookup_miss;
  logic               lru_victim;
  logic               lru_hit_wr;
  logic               lru_wr_en;
  logic [INDEX_W-1:0] lru_wr_set;
  logic               lru_wr_bit;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lookup_valid <= 1'b0;
    end else begin
      lookup_valid <= cpu_req.access && enabled && !init_busy;
    end
  end

  always_ff @(posedge clk) begin
    lookup_addr <= cpu_req.addr;
  end

  icache_way way0_inst (
    .clk          (clk),
    .rd_addr      (cpu_req.addr),
    .cmp_addr     (lookup_addr),
    .tag_wr       (tag_wr0),
    .tag_wr_data  (tag_wr_data),
    .wr_set       (fill_set),
    .data_wr      (data_wr0),
    .data_wr_addr (mem_addr[INDEX_W+OFFSET_W-1:0]),
    .data_wr_word (m_data),
    .tag_hit      (tag_hit0),
    .data         (data0)
  );

  icache_way way1_inst (
    .clk          (clk),
    .rd_addr      (cpu_req.addr),
    .cmp_addr     (lookup_addr),
    .tag_wr       (tag_wr1),
    .tag_wr_data  (tag_wr_data),
    .wr_set       (fill_set),
    .data_wr      (data_wr1),
    .data_wr_addr (mem_addr[INDEX_W+OFFSET_W-1:0]),
    .data_wr_word (m_data),
    .tag_hit      (tag_hit1),
    .data         (data1)
  );

  // Words of the line in flight hit once they have arrived
  assign in_window = filling && filled_mask[addr_offset(lookup_addr)] &&
                     (lookup_addr[ADDR_W-1:OFFSET_W] == mem_addr[ADDR_W-1:OFFSET_W]);
  assign hit0 = lookup_valid && (tag_hit0 || (in_window && !victim_way));
  assign hit1 = lookup_valid && (tag_hit1 || (in_window && victim_way));
  assign c_hit = hit0 || hit1;
  assign lookup_miss = lookup_valid && !c_hit;

  icache_fill fill_inst (
    .clk         (clk),
    .reset       (reset),
    .enabled     (enabled),
    .cpu_req     (cpu_req),
    .lookup_miss (lookup_miss),
    .lru_victim  (lru_victim),
    .m_ack       (m_ack),
    .mem_addr    (mem_addr),
    .mem_access  (mem_access),
    .filling     (filling),
    .fill_set    (fill_set),
    .filled_mask (filled_mask),
    .victim_way  (victim_way),
    .tag_wr0     (tag_wr0),
    .tag_wr1     (tag_wr1),
    .tag_wr_data (tag_wr_data),
    .data_wr0    (data_wr0),
    .data_wr1    (data_wr1),
    .lru_wr      (lru_wr),
    .init_busy   (init_busy)
  );

  // LRU bit names the next victim; hit updates win over the fill end
  assign lru_hit_wr = c_hit && enabled;
  assign lru_wr_en = lru_hit_wr || lru_wr;
  assign lru_wr_set = lru_hit_wr ? addr_index(lookup_addr) : fill_set;
  assign lru_wr_bit = lru_hit_wr ? !hit1 : (!init_busy && !victim_way);

  dp_ram #(
    .DEPTH     (SETS),
    .payload_t (logic)
  ) lru_ram_inst (
    .clk     (clk),
    .rd_addr (addr_index(cpu_req.addr)),
    .rd_data (lru_victim),
    .wr_en   (lru_wr_en),
    .wr_addr (lru_wr_set),
    .wr_data (lru_wr_bit)
  );

  // Bypass wires both ports straight through
  assign c_ack = enabled ? c_hit : m_ack;
  assign c_data = enabled ? (hit1 ? data1 : data0) : m_data;
  assign mem_req = enabled ? fetch_req_t'{access: mem_access, addr: mem_addr} : cpu_req;

  a_one_way_hit: assert property (@(posedge clk) disable iff (reset)
    !(hit0 && hit1));

endmodule

`default_nettype wire

/* logic/icache_fill.sv */
/*
 * Cache fill control: reset sweep of the tag entries, miss capture,
 * wrapping line fetch and per-word arrival mask
 */
`timescale 1ns/1ps
`default_nettype none

module icache_fill (
  input  wire logic                           clk,
  input  wire logic                           reset,
  input  wire logic                           enabled,
  input  wire icache_pkg::fetch_req_t         cpu_req,
  input  wire logic                           lookup_miss,
  input  wire logic                           lru_victim,
  input  wire logic                           m_ack,
  output icache_pkg::addr_t                   mem_addr,
  output logic                                mem_access,
  output logic                                filling,
  output logic [icache_pkg::INDEX_W-1:0]      fill_set,
  output logic [icache_pkg::LINE_WORDS-1:0]   filled_mask,
  output logic                                victim_way,
  output logic                                tag_wr0,
  output logic                                tag_wr1,
  output icache_pkg::tag_entry_t              tag_wr_data,
  output logic                                data_wr0,
  output logic                                data_wr1,
  output logic                                lru_wr,
  output logic                                init_busy
);

  import icache_pkg::*;

  logic [INDEX_W-1:0]  sweep_cnt;
  logic [OFFSET_W-1:0] beat_cnt;
  logic                fill_first;
  addr_t               fill_addr;
  logic                fill_start;
  logic                beat;
  logic                last_beat;
  logic                tag_wr;

  // CPU still holds the missing request, so its address is the line to fetch
  assign fill_start = lookup_miss && cpu_req.access && enabled && !filling && !init_busy;
  assign beat = filling && enabled && m_ack;
  assign last_beat = beat && (beat_cnt == OFFSET_W'(LINE_WORDS - 1));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      init_busy <= 1'b1;
      sweep_cnt <= '0;
      filling <= 1'b0;
      fill_first <= 1'b0;
      beat_cnt <= '0;
      filled_mask <= '0;
      victim_way <= 1'b0;
    end else if (init_busy) begin
      sweep_cnt <= sweep_cnt + 1'b1;
      if (sweep_cnt == INDEX_W'(SETS - 1)) begin
        init_busy <= 1'b0;
      end
    end else if (fill_start) begin
      filling <= 1'b1;
      fill_first <= 1'b1;
      beat_cnt <= '0;
      filled_mask <= '0;
      victim_way <= lru_victim;
    end else if (filling) begin
      fill_first <= 1'b0;
      if (beat) begin
        beat_cnt <= beat_cnt + 1'b1;
        filled_mask[addr_offset(fill_addr)] <= 1'b1;
        if (last_beat) begin
          filling <= 1'b0;
        end
      end
    end
  end

  // Offset wraps inside the line after the critical word
  always_ff @(posedge clk) begin
    if (fill_start) begin
      fill_addr <= cpu_req.addr;
    end else if (beat) begin
      fill_addr[OFFSET_W-1:0] <= fill_addr[OFFSET_W-1:0] + 1'b1;
    end
  end

  assign mem_addr = fill_addr;
  assign mem_access = filling;
  assign fill_set = init_busy ? sweep_cnt : addr_index(fill_addr);

  // Victim goes invalid on the first fill cycle, valid again with the last word
  assign tag_wr = fill_first || last_beat;
  assign tag_wr0 = init_busy || (tag_wr && !victim_way);
  assign tag_wr1 = init_busy || (tag_wr && victim_way);
  assign tag_wr_data.valid = last_beat;
  assign tag_wr_data.tag = init_busy ? '0 : addr_tag(fill_addr);

  assign data_wr0 = beat && !victim_way;
  assign data_wr1 = beat && victim_way;
  assign lru_wr = init_busy || last_beat;

  a_beat_only_in_fill: assert property (@(posedge clk) disable iff (reset)
    !filling |=> $stable(beat_cnt));

  a_no_mem_in_init: assert property (@(posedge clk) disable iff (reset)
    init_busy |-> !mem_access && !filling);

endmodule

`default_nettype wire

/* logic/icache_pkg.sv */
/*
 * Instruction cache shared sizes, address fields and packed types
 */
`default_nettype none

package icache_pkg;

  localparam int ADDR_W = 19;
  localparam int LINE_WORDS = 8;
  localparam int OFFSET_W = 3;
  localparam int SETS = 256;
  localparam int INDEX_W = 8;
  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

  typedef logic [15:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // Valid flag sits above the tag in one RAM word
  typedef struct packed {
    logic valid;
    logic [TAG_W-1:0] tag;
  } tag_entry_t;

  typedef struct packed {
    logic access;
    addr_t addr;
  } fetch_req_t;

  // Word address layout is {tag, index, offset}
  function automatic logic [INDEX_W-1:0] addr_index(addr_t a);
    return a[OFFSET_W +: INDEX_W];
  endfunction

  function automatic logic [TAG_W-1:0] addr_tag(addr_t a);
    return a[ADDR_W-1 -: TAG_W];
  endfunction

  function automatic logic [OFFSET_W-1:0] addr_offset(addr_t a);
    return a[OFFSET_W-1:0];
  endfunction

endpackage

`default_nettype wire

/* logic/icache_way.sv */
/*
 * One cache way: tag RAM and line RAM read in parallel,
 * tag compare against the registered lookup address
 */
`timescale 1ns/1ps
`default_nettype none

module icache_way (
  input  wire logic                                          clk,
  input  wire icache_pkg::addr_t                             rd_addr,
  input  wire icache_pkg::addr_t                             cmp_addr,
  input  wire logic                                          tag_wr,
  input  wire icache_pkg::tag_entry_t                        tag_wr_data,
  input  wire logic [icache_pkg::INDEX_W-1:0]                wr_set,
  input  wire logic                                          data_wr,
  input  wire logic [icache_pkg::INDEX_W+icache_pkg::OFFSET_W-1:0] data_wr_addr,
  input  wire icache_pkg::word_t                             data_wr_word,
  output logic                                               tag_hit,
  output icache_pkg::word_t                                  data
);

  import icache_pkg::*;

  tag_entry_t tag_entry;

  dp_ram #(
    .DEPTH     (SETS),
    .payload_t (tag_entry_t)
  ) tag_ram_inst (
    .clk     (clk),
    .rd_addr (addr_index(rd_addr)),
    .rd_data (tag_entry),
    .wr_en   (tag_wr),
    .wr_addr (wr_set),
    .wr_data (tag_wr_data)
  );

  // Line RAM is addressed by {index, offset}
  dp_ram #(
    .DEPTH     (SETS * LINE_WORDS),
    .payload_t (word_t)
  ) data_ram_inst (
    .clk     (clk),
    .rd_addr (rd_addr[INDEX_W+OFFSET_W-1:0]),
    .rd_data (data),
    .wr_en   (data_wr),
    .wr_addr (data_wr_addr),
    .wr_data (data_wr_word)
  );

  assign tag_hit = tag_entry.valid && (tag_entry.tag == addr_tag(cmp_addr));

  // Closing tag write of a fill lands in the same set as its last word
  a_fill_set_match: assert property (@(posedge clk)
    (tag_wr && tag_wr_data.valid && data_wr) |->
      data_wr_addr[INDEX_W+OFFSET_W-1:OFFSET_W] == wr_set);

endmodule

`default_nettype wire

/* tb/icache_tb.sv */
/*
 * Testbench for the two-way instruction cache, directed and random
 * fetches checked against a tag and LRU reference model
 */
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

  import icache_pkg::*;

  localparam int RANDOM_REQS = 40;
  localparam int REQUESTS = 26 + RANDOM_REQS;
  localparam int CYCLE_LIMIT = (SETS + REQUESTS * (LINE_WORDS * 5 + 4)) * 3 / 2;

  logic       clk;
  logic       reset;
  logic       enabled;
  fetch_req_t cpu_req;
  word_t      c_data;
  logic       c_ack;
  fetch_req_t mem_req;
  word_t      m_data;
  logic       m_ack;
  addr_t      served_addr;

  logic [TAG_W-1:0] ref_tag [SETS][2];
  logic             ref_valid [SETS][2];
  logic             ref_lru [SETS];
  addr_t            beat_log [$];
  integer           seed = 32'h5855_abac;
  int errors = 0;
  int checks = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int test_base = 0;
  int misses = 0;
  int cycles = 0;

  icache_2way icache_2way_inst (
    .clk     (clk),
    .reset   (reset),
    .enabled (enabled),
    .cpu_req (cpu_req),
    .c_data  (c_data),
    .c_ack   (c_ack),
    .mem_req (mem_req),
    .m_data  (m_data),
    .m_ack   (m_ack)
  );

  mem_model mem_model_inst (
    .clk         (clk),
    .mem_req     (mem_req),
    .m_data      (m_data),
    .m_ack       (m_ack),
    .served_addr (served_addr)
  );

  function automatic word_t mem_word(addr_t a);
    return (a[15:0] * 16'h9e37) ^ word_t'(a[ADDR_W-1:16]);
  endfunction

  function automatic addr_t make_addr(int tag, int index, int offset);
    return {TAG_W'(tag), INDEX_W'(index), OFFSET_W'(offset)};
  endfunction

  // Predicts hit or miss, then updates tags and LRU as the cache would
  function automatic logic model_lookup(addr_t a);
    logic [INDEX_W-1:0] s;
    logic [TAG_W-1:0] t;
    logic w;
    s = a[OFFSET_W +: INDEX_W];
    t = a[ADDR_W-1 -: TAG_W];
    for (int i = 0; i < 2; i++) begin
      if (ref_valid[s][i] && ref_tag[s][i] == t) begin
        ref_lru[s] = (i == 0);
        return 1'b1;
      end
    end
    w = ref_lru[s];
    ref_valid[s][w] = 1'b1;
    ref_tag[s][w] = t;
    ref_lru[s] = !w;
    return 1'b0;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("FAIL %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic fetch(input addr_t a);
    cpu_req <= {1'b1, a};
    @(negedge clk);
    while (!c_ack) begin
      @(negedge clk);
    end
    cpu_req <= {1'b0, a};
  endtask

  // Open fill ends, then its last beat reaches the log
  task automatic settle();
    while (mem_req.access) begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  // A hit is acked in the cycle after the request
  task automatic request(input addr_t a);
    int base;
    int expected;
    int start;
    base = beat_log.size();
    expected = model_lookup(a) ? 0 : LINE_WORDS;
    if (expected != 0) begin
      misses++;
    end
    start = cycles;
    fetch(a);
    if (expected == 0) begin
      check_count("hit latency", cycles - start, 1);
    end
    settle();
    check_count("beats", beat_log.size() - base, expected);
  endtask

  task automatic bypass_request(input addr_t a);
    int base;
    base = beat_log.size();
    fetch(a);
    settle();
    check_count("bypass beats", beat_log.size() - base, 1);
    check_addr("mem_req.addr", beat_log[base], a);
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_base) begin
      $display("Test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: failed", tests_run, name);
    end
    test_base = errors;
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(negedge clk) begin
    if (m_ack) begin
      beat_log.push_back(served_addr);
    end
  end

  // Every acked word must match the memory contents
  always @(negedge clk) begin
    if (cpu_req.access && c_ack) begin
      check_word("c_data", c_data, mem_word(cpu_req.addr));
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles == CYCLE_LIMIT) begin
      $display("Timeout: run still busy after %0d cycles", CYCLE_LIMIT);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    addr_t a;
    int base;
    int i;
    logic [31:0] r;
    reset = 1'b1;
    enabled = 1'b1;
    cpu_req = '0;
    for (i = 0; i < SETS; i++) begin
      ref_valid[i][0] = 1'b0;
      ref_valid[i][1] = 1'b0;
      ref_lru[i] = 1'b0;
    end
    repeat (3) @(negedge clk);
    reset <= 1'b0;

    // First request also waits out the tag sweep
    a = make_addr(8'h12, 8'h05, 5);
    base = beat_log.size();
    request(a);
    for (i = 0; i < LINE_WORDS; i++) begin
      check_addr("mem_req.addr", beat_log[base + i],
                 {a[ADDR_W-1:OFFSET_W], OFFSET_W'(5 + i)});
    end
    for (i = 1; i < LINE_WORDS; i++) begin
      request({a[ADDR_W-1:OFFSET_W], OFFSET_W'(5 + i)});
    end
    end_test("cold miss then hits");

    a = make_addr(8'h21, 8'h40, 2);
    base = beat_log.size();
    void'(model_lookup(a));
    void'(model_lookup(addr_t'(a + 4)));
    fetch(a);
    fetch(addr_t'(a + 4));
    settle();
    check_count("beats", beat_log.size() - base, LINE_WORDS);
    check_addr("mem_req.addr", beat_log[base], a);
    end_test("critical word in fill window");

    request(make_addr(8'h01, 8'h80, 0));
    request(make_addr(8'h02, 8'h80, 0));
    for (i = 0; i < 6; i++) begin
      request(make_addr(1 + i % 2, 8'h80, i));
    end
    end_test("two-way retention");

    // Tag 01 is least recently used here
    request(make_addr(8'h03, 8'h80, 1));
    request(make_addr(8'h02, 8'h80, 2));
    request(make_addr(8'h01, 8'h80, 3));
    end_test("LRU replacement");

    enabled <= 1'b0;
    bypass_request(make_addr(8'h12, 8'h05, 1));
    bypass_request(make_addr(8'h7f, 8'h11, 6));
    bypass_request(make_addr(8'h02, 8'h80, 2));
    enabled <= 1'b1;
    request(make_addr(8'h12, 8'h05, 1));
    request(make_addr(8'h02, 8'h80, 4));
    end_test("bypass");

    base = beat_log.size();
    misses = 0;
    for (i = 0; i < RANDOM_REQS; i++) begin
      r = $random(seed);
      request(make_addr(r[1:0], 8'h30 + r[3:2], r[6:4]));
    end
    check_count("fills", (beat_log.size() - base) / LINE_WORDS, misses);
    end_test("random stream");

    $display("Tests: %0d run, %0d failed; checks: %0d, errors: %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/mem_model.sv */
/*
 * Memory responder, acks one word per request after a random delay
 */
`timescale 1ns/1ps
`default_nettype none

module mem_model (
  input  wire logic                   clk,
  input  wire icache_pkg::fetch_req_t mem_req,
  output icache_pkg::word_t           m_data,
  output logic                        m_ack,
  output icache_pkg::addr_t           served_addr
);

  import icache_pkg::*;

  integer seed = 32'h5855_abac;
  int delay;

  function automatic word_t mem_word(addr_t a);
    return (a[15:0] * 16'h9e37) ^ word_t'(a[ADDR_W-1:16]);
  endfunction

  // Ack lasts one cycle, then the request is looked at again
  initial begin
    m_ack = 1'b0;
    m_data = '0;
    served_addr = '0;
    forever begin
      @(negedge clk);
      if (mem_req.access) begin
        delay = $random(seed) & 3;
        repeat (delay) @(negedge clk);
        m_ack <= 1'b1;
        m_data <= mem_word(mem_req.addr);
        served_addr <= mem_req.addr;
        @(negedge clk);
        m_ack <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire
